//--- logic/gat_pkg.sv
package gat_pkg;

  // ===================================================================
  // number formats
  // ===================================================================

  // attention weights and coefficients share one byte format
  localparam int DATA_WIDTH = 8;

  // one transformed feature of the WH word
  localparam int WH_DATA_WIDTH = 12;

  // ===================================================================
  // element types
  // ===================================================================

  // one signed attention weight
  typedef logic signed [DATA_WIDTH-1:0] a_elem_t;

  // one signed WH feature
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_elem_t;

  // coefficient after shift, truncation and ReLU
  typedef logic [DATA_WIDTH-1:0] coef_t;

  // ===================================================================
  // helpers
  // ===================================================================

  // full-precision dot product width for num_feature terms
  // a product needs DATA_WIDTH + WH_DATA_WIDTH bits,
  // each tree level adds one more bit
  function automatic int prod_width(input int num_feature);
    return DATA_WIDTH + WH_DATA_WIDTH + $clog2(num_feature);
  endfunction

endpackage

//--- logic/coef_dot_if.sv
`timescale 1ns/1ps

interface coef_dot_if #(
  parameter int NUM_FEATURE_OUT = 8
);
  import gat_pkg::*;

  localparam int PW = prod_width(NUM_FEATURE_OUT);

  // result of one WH word, valid for a single cycle
  logic                 dot_vld;
  logic                 src_flag;
  logic signed [PW-1:0] src_dot;
  logic signed [PW-1:0] nbr_dot;

  // dot-product pipeline side
  modport pipe_mp (
    output dot_vld, src_flag, src_dot, nbr_dot
  );

  // coefficient combiner side
  modport comb_mp (
    input dot_vld, src_flag, src_dot, nbr_dot
  );

endinterface

//--- logic/attn_weight_regs.sv
`timescale 1ns/1ps

module attn_weight_regs #(
  parameter int NUM_FEATURE_OUT = 8
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          a_load_i,
  input  gat_pkg::a_elem_t [2*NUM_FEATURE_OUT-1:0]      a_i,
  output gat_pkg::a_elem_t [NUM_FEATURE_OUT-1:0]        a_src_o,
  output gat_pkg::a_elem_t [NUM_FEATURE_OUT-1:0]        a_nbr_o
);
  import gat_pkg::*;

  // held halves of the attention vector
  a_elem_t [NUM_FEATURE_OUT-1:0] src_q;
  a_elem_t [NUM_FEATURE_OUT-1:0] nbr_q;

  // ===================================================================
  // weight capture
  // ===================================================================

  // lower half weights the source node, upper half the neighbour
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_q <= '0;
      nbr_q <= '0;
    end else if (a_load_i) begin
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        src_q[k] <= a_i[k];
        nbr_q[k] <= a_i[NUM_FEATURE_OUT+k];
      end
    end
  end

  // stable until the next load strobe
  assign a_src_o = src_q;
  assign a_nbr_o = nbr_q;

endmodule

//--- logic/coef_dot_pipe.sv
`timescale 1ns/1ps

module coef_dot_pipe #(
  parameter int NUM_FEATURE_OUT = 8
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              wh_vld_i,
  input  logic [NUM_FEATURE_OUT*gat_pkg::WH_DATA_WIDTH:0]   wh_data_i,
  input  gat_pkg::a_elem_t [NUM_FEATURE_OUT-1:0]            a_src_i,
  input  gat_pkg::a_elem_t [NUM_FEATURE_OUT-1:0]            a_nbr_i,
  coef_dot_if.pipe_mp                                       dot
);
  import gat_pkg::*;

  localparam int PW         = prod_width(NUM_FEATURE_OUT);
  localparam int NUM_STAGES = $clog2(NUM_FEATURE_OUT) + 1;
  localparam int WH_W       = NUM_FEATURE_OUT * WH_DATA_WIDTH + 1;

  // tree nodes stored heap style
  // node 0 is the root, leaves start at NUM_FEATURE_OUT-1
  localparam int NUM_NODES = 2 * NUM_FEATURE_OUT - 1;
  localparam int LEAF_BASE = NUM_FEATURE_OUT - 1;

  // input capture
  logic                               vld_q;
  logic [WH_W-1:0]                    wh_q;
  wh_elem_t [NUM_FEATURE_OUT-1:0]     wh_feat;

  // control travelling beside the data
  logic [NUM_STAGES-1:0]              vld_sr;
  logic [NUM_STAGES-1:0]              flag_sr;

  logic signed [PW-1:0]               src_node [NUM_NODES];
  logic signed [PW-1:0]               nbr_node [NUM_NODES];

  // ===================================================================
  // input register
  // ===================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= wh_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      wh_q <= wh_data_i;
    end
  end

  // features above the flag bit, feature 0 lowest
  assign wh_feat = wh_q[WH_W-1:1];

  // ===================================================================
  // multiplier stage and adder trees
  // ===================================================================

  for (genvar k = 0; k < NUM_FEATURE_OUT; k++) begin : g_leaf
    always_ff @(posedge clk) begin
      src_node[LEAF_BASE+k] <= PW'($signed(a_src_i[k])) * PW'($signed(wh_feat[k]));
      nbr_node[LEAF_BASE+k] <= PW'($signed(a_nbr_i[k])) * PW'($signed(wh_feat[k]));
    end
  end

  // one register per tree level, children at 2n+1 and 2n+2
  for (genvar n = 0; n < LEAF_BASE; n++) begin : g_node
    always_ff @(posedge clk) begin
      src_node[n] <= src_node[2*n+1] + src_node[2*n+2];
      nbr_node[n] <= nbr_node[2*n+1] + nbr_node[2*n+2];
    end
  end

  // ===================================================================
  // valid and source flag delay
  // ===================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr  <= '0;
      flag_sr <= '0;
    end else begin
      vld_sr  <= {vld_sr[NUM_STAGES-2:0], vld_q};
      flag_sr <= {flag_sr[NUM_STAGES-2:0], wh_q[0]};
    end
  end

  // root is ready NUM_STAGES edges after capture
  assign dot.dot_vld  = vld_sr[NUM_STAGES-1];
  assign dot.src_flag = flag_sr[NUM_STAGES-1];
  assign dot.src_dot  = src_node[0];
  assign dot.nbr_dot  = nbr_node[0];

endmodule

//--- logic/coef_combine.sv
`timescale 1ns/1ps

module coef_combine #(
  parameter int NUM_FEATURE_OUT = 8,
  parameter int COEF_SHIFT      = 10
) (
  input  logic          clk,
  input  logic          rst_n,
  coef_dot_if.comb_mp   dot,
  output logic          push_o,
  output gat_pkg::coef_t push_data_o
);
  import gat_pkg::*;

  localparam int PW = prod_width(NUM_FEATURE_OUT);

  logic                 new_src;
  logic signed [PW-1:0] src_hold_q;
  logic signed [PW-1:0] src_term;
  logic signed [PW:0]   sum_w;
  logic signed [PW:0]   shifted_w;
  coef_t                coef_byte;

  // ===================================================================
  // source term hold
  // ===================================================================

  assign new_src = dot.dot_vld && dot.src_flag;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_hold_q <= '0;
    end else if (new_src) begin
      src_hold_q <= dot.src_dot;
    end
  end

  // flagged word already uses its own source sum
  assign src_term = new_src ? dot.src_dot : src_hold_q;

  // ===================================================================
  // coefficient rule
  // ===================================================================

  // one guard bit so the add cannot wrap
  assign sum_w     = (PW+1)'(src_term) + (PW+1)'(dot.nbr_dot);
  assign shifted_w = sum_w >>> COEF_SHIFT;
  assign coef_byte = shifted_w[DATA_WIDTH-1:0];

  // relu on the truncated byte
  assign push_data_o = coef_byte[DATA_WIDTH-1] ? '0 : coef_byte;

  // one push per dot result, the FIFO handles full
  assign push_o = dot.dot_vld;

endmodule

//--- logic/coef_fifo.sv
`timescale 1ns/1ps

module coef_fifo #(
  parameter int COEF_FIFO_DEPTH = 8
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           push_i,
  input  gat_pkg::coef_t push_data_i,
  input  logic           pop_i,
  output gat_pkg::coef_t head_o,
  output logic           empty_o,
  output logic           ovf_o
);
  import gat_pkg::*;

  localparam int AW = (COEF_FIFO_DEPTH > 1) ? $clog2(COEF_FIFO_DEPTH) : 1;
  localparam int CW = $clog2(COEF_FIFO_DEPTH + 1);

  coef_t           mem [COEF_FIFO_DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            full;
  logic            do_push;
  logic            do_pop;

  assign empty_o = (count == '0);
  assign full    = (count == CW'(COEF_FIFO_DEPTH));

  // a pop frees the slot for a push in the same cycle
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full || do_pop);

  // ===================================================================
  // storage
  // ===================================================================

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // fall-through head
  assign head_o = mem[rd_ptr];

  // ===================================================================
  // pointers, count and overflow
  // ===================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf_o  <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(COEF_FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(COEF_FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky until reset
      if (push_i && !do_push) begin
        ovf_o <= 1'b1;
      end
    end
  end

endmodule

//--- logic/gat_coef_top.sv
`timescale 1ns/1ps

module gat_coef_top #(
  parameter int NUM_FEATURE_OUT = 8,
  parameter int COEF_SHIFT      = 10,
  parameter int COEF_FIFO_DEPTH = 8
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  // attention weights
  input  logic                                              a_load_i,
  input  gat_pkg::a_elem_t [2*NUM_FEATURE_OUT-1:0]          a_i,
  // WH word stream
  input  logic                                              wh_vld_i,
  input  logic [NUM_FEATURE_OUT*gat_pkg::WH_DATA_WIDTH:0]   wh_data_i,
  // coefficient FIFO
  input  logic                                              coef_rd_i,
  output gat_pkg::coef_t                                    coef_o,
  output logic                                              coef_empty_o,
  output logic                                              coef_ovf_o
);
  import gat_pkg::*;

  a_elem_t [NUM_FEATURE_OUT-1:0] a_src;
  a_elem_t [NUM_FEATURE_OUT-1:0] a_nbr;
  logic                          push;
  coef_t                         push_data;

  // pipeline to combiner
  coef_dot_if #(.NUM_FEATURE_OUT(NUM_FEATURE_OUT)) i_dot ();

  attn_weight_regs #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) i_weights (
    .clk      (clk),
    .rst_n    (rst_n),
    .a_load_i (a_load_i),
    .a_i      (a_i),
    .a_src_o  (a_src),
    .a_nbr_o  (a_nbr)
  );

  coef_dot_pipe #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) i_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .wh_vld_i  (wh_vld_i),
    .wh_data_i (wh_data_i),
    .a_src_i   (a_src),
    .a_nbr_i   (a_nbr),
    .dot       (i_dot.pipe_mp)
  );

  coef_combine #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .COEF_SHIFT      (COEF_SHIFT)
  ) i_combine (
    .clk         (clk),
    .rst_n       (rst_n),
    .dot         (i_dot.comb_mp),
    .push_o      (push),
    .push_data_o (push_data)
  );

  coef_fifo #(
    .COEF_FIFO_DEPTH (COEF_FIFO_DEPTH)
  ) i_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (coef_rd_i),
    .head_o      (coef_o),
    .empty_o     (coef_empty_o),
    .ovf_o       (coef_ovf_o)
  );

endmodule

//--- dv/gat_coef_asserts.sv
`timescale 1ns/1ps

module gat_coef_asserts #(
  parameter int COEF_FIFO_DEPTH = 8
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [$clog2(COEF_FIFO_DEPTH+1)-1:0] count_i,
  input  logic                                 ovf_i,
  input  logic                                 push_i,
  input  gat_pkg::coef_t                       push_data_i
);
  import gat_pkg::*;

  localparam int CW = $clog2(COEF_FIFO_DEPTH + 1);

  // ===================================================================
  // FIFO state
  // ===================================================================

  // occupancy never passes a full FIFO
  a_count_range: assert property (
    @(posedge clk) disable iff (!rst_n) count_i <= CW'(COEF_FIFO_DEPTH)
  ) else $error("FIFO count went past the FIFO depth");

  // overflow is sticky
  a_ovf_sticky: assert property (
    @(posedge clk) disable iff (!rst_n) ovf_i |=> ovf_i
  ) else $error("overflow flag fell without a reset");

  // ===================================================================
  // combiner output, seen at the FIFO write port
  // ===================================================================

  a_push_relu: assert property (
    @(posedge clk) disable iff (!rst_n) push_i |-> !push_data_i[DATA_WIDTH-1]
  ) else $error("pushed coefficient has its sign bit set");

endmodule

bind coef_fifo gat_coef_asserts #(
  .COEF_FIFO_DEPTH (COEF_FIFO_DEPTH)
) i_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .count_i     (count),
  .ovf_i       (ovf_o),
  .push_i      (push_i),
  .push_data_i (push_data_i)
);

//--- dv/tb_gat_coef.sv
`timescale 1ns/1ps

module tb_gat_coef;
  import gat_pkg::*;

  localparam int F          = 8;
  localparam int SHIFT      = 10;
  localparam int DEPTH      = 8;
  localparam int LAT        = $clog2(F) + 2;
  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 10;
  localparam int N_RAND     = 200;
  localparam int N_RELU     = 60;
  localparam int N_BP       = 20;
  localparam int N_RELOAD   = 40;
  // words take at most two cycles each, plus loads, idles and drains
  localparam int RUN_CYCLES = RST_CYCLES + 5 + 16 + 2 * (N_RAND + N_RELU + N_BP + N_RELOAD)
                              + 4 * (LAT + DEPTH + 4);
  localparam int WATCHDOG_NS = (RUN_CYCLES + 20) * CLK_PERIOD;

  logic                          clk;
  logic                          rst_n;
  logic                          a_load_i;
  a_elem_t [2*F-1:0]             a_i;
  logic                          wh_vld_i;
  logic [F*WH_DATA_WIDTH:0]      wh_data_i;
  logic                          coef_rd_i;
  coef_t                         coef_o;
  logic                          coef_empty_o;
  logic                          coef_ovf_o;

  // model state
  logic [31:0] rng_state;
  int          m_a [2*F];
  longint      m_src_hold;
  logic        dl_vld [LAT];
  logic [7:0]  dl_data [LAT];
  logic [7:0]  mfifo [$];
  logic        m_ovf;
  int          err_cnt;
  int          relu_cnt;
  int          pop_cnt;

  gat_coef_top #(
    .NUM_FEATURE_OUT (F),
    .COEF_SHIFT      (SHIFT),
    .COEF_FIFO_DEPTH (DEPTH)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .a_load_i     (a_load_i),
    .a_i          (a_i),
    .wh_vld_i     (wh_vld_i),
    .wh_data_i    (wh_data_i),
    .coef_rd_i    (coef_rd_i),
    .coef_o       (coef_o),
    .coef_empty_o (coef_empty_o),
    .coef_ovf_o   (coef_ovf_o)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // ===================================================================
  // random numbers and coefficient rule
  // ===================================================================

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // arithmetic shift, then keep the low byte
  function automatic logic [7:0] shifted_byte(input longint sum);
    longint sh;
    sh = sum >>> SHIFT;
    return sh[7:0];
  endfunction

  function automatic logic line_busy();
    logic busy;
    busy = 1'b0;
    for (int i = 0; i < LAT; i++) begin
      busy = busy | dl_vld[i];
    end
    return busy;
  endfunction

  // ===================================================================
  // model update and output checks
  // ===================================================================

  task automatic check_outputs();
    assert (coef_empty_o === (mfifo.size() == 0)) else begin
      $display("FAILED coef_empty_o expected %h got %h", (mfifo.size() == 0), coef_empty_o);
      err_cnt++;
    end
    assert (coef_ovf_o === m_ovf) else begin
      $display("FAILED coef_ovf_o expected %h got %h", m_ovf, coef_ovf_o);
      err_cnt++;
    end
    if (mfifo.size() != 0) begin
      assert (coef_o === mfifo[0]) else begin
        $display("FAILED coef_o expected %h got %h", mfifo[0], coef_o);
        err_cnt++;
      end
    end
  endtask

  // one clock edge of the delay line and the FIFO
  task automatic advance_model(input logic vld, input logic [7:0] coef, input logic rd);
    logic       out_vld;
    logic [7:0] out_data;
    logic       do_pop;
    logic       do_push;
    out_vld  = dl_vld[LAT-1];
    out_data = dl_data[LAT-1];
    for (int i = LAT - 1; i > 0; i--) begin
      dl_vld[i]  = dl_vld[i-1];
      dl_data[i] = dl_data[i-1];
    end
    dl_vld[0]  = vld;
    dl_data[0] = coef;
    do_pop  = rd && (mfifo.size() != 0);
    do_push = out_vld && ((mfifo.size() < DEPTH) || do_pop);
    if (do_pop) begin
      void'(mfifo.pop_front());
      pop_cnt++;
    end
    if (do_push) begin
      mfifo.push_back(out_data);
    end
    if (out_vld && !do_push) begin
      m_ovf = 1'b1;
    end
  endtask

  task automatic step(input logic vld, input logic [7:0] coef, input logic rd);
    check_outputs();
    wh_vld_i  = vld;
    coef_rd_i = rd;
    advance_model(vld, coef, rd);
    @(negedge clk);
  endtask

  // ===================================================================
  // stimulus
  // ===================================================================

  task automatic load_weights(input logic negative);
    logic [31:0] r;
    int          w;
    for (int k = 0; k < 2 * F; k++) begin
      r = rand32();
      if (negative) begin
        w = -64 - int'(r[5:0]);
      end else begin
        w = int'($signed(r[7:0]));
      end
      a_i[k] = w[7:0];
      m_a[k] = w;
    end
    a_load_i = 1'b1;
    step(1'b0, 8'h00, 1'b0);
    a_load_i = 1'b0;
  endtask

  task automatic send_word(input logic flag, input logic pos_feat, input logic rd);
    logic [31:0] r;
    int          f;
    longint      src_sum;
    longint      nbr_sum;
    logic [7:0]  raw;
    src_sum = 0;
    nbr_sum = 0;
    for (int k = 0; k < F; k++) begin
      r = rand32();
      if (pos_feat) begin
        f = int'(r[10:0]);
      end else begin
        f = int'($signed(r[11:0]));
      end
      wh_data_i[WH_DATA_WIDTH*k+1 +: WH_DATA_WIDTH] = f[WH_DATA_WIDTH-1:0];
      src_sum += m_a[k] * f;
      nbr_sum += m_a[F+k] * f;
    end
    wh_data_i[0] = flag;
    if (flag) begin
      m_src_hold = src_sum;
    end
    raw = shifted_byte(m_src_hold + nbr_sum);
    if (raw[7]) begin
      relu_cnt++;
    end
    step(1'b1, raw[7] ? 8'h00 : raw, rd);
  endtask

  // first word always carries the source flag
  task automatic stream(input int n, input logic later_flags, input logic pos_feat,
                        input logic reads);
    logic [31:0] r;
    logic        flag;
    for (int i = 0; i < n; i++) begin
      r = rand32();
      if (r[1:0] == 2'b00) begin
        step(1'b0, 8'h00, reads && (r[11:10] != 2'b00));
      end
      flag = (i == 0) || (later_flags && (r[4:2] == 3'b000));
      send_word(flag, pos_feat, reads && (r[9:8] != 2'b00));
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((mfifo.size() != 0 || line_busy()) && n < LAT + DEPTH + 4) begin
      step(1'b0, 8'h00, 1'b1);
      n++;
    end
  endtask

  // ===================================================================
  // test sequence
  // ===================================================================

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    a_load_i   = 1'b0;
    a_i        = '0;
    wh_vld_i   = 1'b0;
    wh_data_i  = '0;
    coef_rd_i  = 1'b0;
    rng_state  = 32'h0623d71a;
    m_src_hold = 0;
    m_ovf      = 1'b0;
    err_cnt    = 0;
    relu_cnt   = 0;
    pop_cnt    = 0;
    for (int i = 0; i < LAT; i++) begin
      dl_vld[i]  = 1'b0;
      dl_data[i] = 8'h00;
    end
    for (int k = 0; k < 2 * F; k++) begin
      m_a[k] = 0;
    end
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // reads on an empty FIFO
    repeat (5) step(1'b0, 8'h00, 1'b1);

    // random weights, random source flags
    load_weights(1'b0);
    repeat (3) step(1'b0, 8'h00, 1'b0);
    stream(N_RAND, 1'b1, 1'b0, 1'b1);
    drain();

    // negative weights, positive features
    load_weights(1'b1);
    step(1'b0, 8'h00, 1'b0);
    relu_cnt = 0;
    stream(N_RELU, 1'b1, 1'b1, 1'b1);
    drain();
    assert (relu_cnt > 0) else begin
      $display("no coefficient in the negative-sum burst took the ReLU path");
      err_cnt++;
    end

    // no reads, so the FIFO fills and drops
    stream(N_BP, 1'b0, 1'b0, 1'b0);
    assert (m_ovf) else begin
      $display("the burst without reads did not overflow the FIFO");
      err_cnt++;
    end
    drain();

    // reload while idle
    load_weights(1'b0);
    step(1'b0, 8'h00, 1'b0);
    stream(N_RELOAD, 1'b1, 1'b0, 1'b1);
    drain();
    check_outputs();

    $display("errors: %0d, coefficients popped: %0d", err_cnt, pop_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the test sequence did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- filelist.f
logic/gat_pkg.sv
logic/coef_dot_if.sv
logic/attn_weight_regs.sv
logic/coef_dot_pipe.sv
logic/coef_combine.sv
logic/coef_fifo.sv
logic/gat_coef_top.sv
dv/gat_coef_asserts.sv
dv/tb_gat_coef.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_gat_coef -o tb_gat_coef

status=0
./obj_dir/tb_gat_coef > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
